// File: hdl/apb_port.sv
/*
  apb host port
  maps bus transfers onto memory requests and the control/status register
*/
`timescale 1ns/10ps

module apb_port (
  input  logic                clk,
  input  logic                rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  stencil_pkg::paddr_t paddr,
  input  stencil_pkg::data_t  pwdata,
  output stencil_pkg::data_t  prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                start,
  input  logic                busy,
  input  logic                done,
  output logic                req_valid,
  output logic                req_write,
  output stencil_pkg::maddr_t req_addr,
  output stencil_pkg::data_t  req_wdata,
  input  logic                req_ready,
  input  logic                rsp_valid,
  input  stencil_pkg::data_t  rsp_rdata
);

  logic               access;
  logic               is_mem;
  logic               is_ctrl;
  logic               is_err;
  logic               issued;
  logic               rsp_seen;
  stencil_pkg::data_t rd_latch;

  // access phase decode
  assign access = psel & penable;
  assign is_mem = (paddr < stencil_pkg::CTRL_ADDR);
  assign is_ctrl = (paddr == stencil_pkg::CTRL_ADDR);
  assign is_err = !is_mem && !is_ctrl;

  // one request per transfer, held back once accepted
  assign req_valid = access & is_mem & !issued;
  assign req_write = pwrite;
  assign req_addr = paddr[6:0];
  assign req_wdata = pwdata;

  // memory transfers wait for the reply, the rest finish at once
  assign pready = access & (is_mem ? rsp_seen : 1'b1);
  assign pslverr = access & is_err;

  assign start = access & is_ctrl & pwrite & pwdata[0] & !busy;

  always_comb begin
    if (!access || is_err) begin
      prdata = '0;
    end else if (is_ctrl) begin
      prdata = {6'd0, done, busy};
    end else begin
      prdata = rd_latch;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issued <= 1'b0;
      rsp_seen <= 1'b0;
    end else if (pready) begin
      issued <= 1'b0;
      rsp_seen <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        issued <= 1'b1;
      end
      if (rsp_valid) begin
        rsp_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) begin
      rd_latch <= rsp_rdata;
    end
  end

endmodule

// File: hdl/cache_mem.sv
/*
  direct-mapped write-through cache with its backing byte array
  read misses fill a whole line before replying
*/
`timescale 1ns/10ps

module cache_mem #(
  parameter int LINE_COUNT = stencil_pkg::LINE_COUNT_DEF
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  logic                req_write,
  input  stencil_pkg::maddr_t req_addr,
  input  stencil_pkg::data_t  req_wdata,
  output logic                req_ready,
  output logic                rsp_valid,
  output stencil_pkg::data_t  rsp_rdata
);

  localparam int ADDR_W = $bits(stencil_pkg::maddr_t);
  localparam int OFF_W = $clog2(stencil_pkg::LINE_BYTES);
  localparam int IDX_W = $clog2(LINE_COUNT);
  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;
  localparam int CNT_W = $clog2(stencil_pkg::LINE_BYTES + 1);
  localparam logic [CNT_W-1:0] FILL_END = CNT_W'(stencil_pkg::LINE_BYTES);

  typedef enum logic {
    S_IDLE,
    S_FILL
  } state_t;

  state_t              state;
  stencil_pkg::data_t  backing [2**ADDR_W];
  stencil_pkg::data_t  line_data [LINE_COUNT * stencil_pkg::LINE_BYTES];
  logic [TAG_W-1:0]    tags [LINE_COUNT];
  logic [LINE_COUNT-1:0] line_valid;

  logic [TAG_W-1:0]    req_tag;
  logic [IDX_W-1:0]    req_idx;
  logic [OFF_W-1:0]    req_off;
  logic                hit;
  stencil_pkg::maddr_t fill_addr;
  logic [CNT_W-1:0]    fill_cnt;
  logic [IDX_W-1:0]    fill_idx;
  logic [OFF_W-1:0]    fill_off;

  assign {req_tag, req_idx, req_off} = req_addr;
  assign hit = line_valid[req_idx] && (tags[req_idx] == req_tag);
  assign fill_idx = fill_addr[OFF_W +: IDX_W];
  assign fill_off = fill_cnt[OFF_W-1:0];

  // one request at a time
  assign req_ready = (state == S_IDLE);

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      rsp_valid <= 1'b0;
      line_valid <= '0;
      fill_cnt <= '0;
    end else begin
      rsp_valid <= 1'b0;
      if (state == S_IDLE) begin
        fill_cnt <= '0;
        if (req_valid) begin
          if (req_write || hit) begin
            rsp_valid <= 1'b1;
          end else begin
            state <= S_FILL;
          end
        end
      end else begin
        fill_cnt <= fill_cnt + 1'b1;
        if (fill_cnt == FILL_END) begin
          state <= S_IDLE;
          rsp_valid <= 1'b1;
          line_valid[fill_idx] <= 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // arrays and reply data
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      if (req_valid) begin
        fill_addr <= req_addr;
        if (req_write) begin
          // write-through, no allocate on a write miss
          backing[req_addr] <= req_wdata;
          rsp_rdata <= req_wdata;
          if (hit) begin
            line_data[{req_idx, req_off}] <= req_wdata;
          end
        end else begin
          rsp_rdata <= line_data[{req_idx, req_off}];
        end
      end
    end else if (fill_cnt != FILL_END) begin
      line_data[{fill_idx, fill_off}] <= backing[{fill_addr[ADDR_W-1:OFF_W], fill_off}];
    end else begin
      tags[fill_idx] <= fill_addr[ADDR_W-1 -: TAG_W];
      rsp_rdata <= backing[fill_addr];
    end
  end

endmodule

// File: hdl/req_arbiter.sv
/*
  round-robin request arbiter
  shares the cache between engine and host, replies go back to the owner
*/
`timescale 1ns/10ps

module req_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  logic                eng_req_valid,
  input  logic                eng_req_write,
  input  stencil_pkg::maddr_t eng_req_addr,
  input  stencil_pkg::data_t  eng_req_wdata,
  output logic                eng_req_ready,
  output logic                eng_rsp_valid,
  output stencil_pkg::data_t  eng_rsp_rdata,
  input  logic                host_req_valid,
  input  logic                host_req_write,
  input  stencil_pkg::maddr_t host_req_addr,
  input  stencil_pkg::data_t  host_req_wdata,
  output logic                host_req_ready,
  output logic                host_rsp_valid,
  output stencil_pkg::data_t  host_rsp_rdata,
  output logic                mem_req_valid,
  output logic                mem_req_write,
  output stencil_pkg::maddr_t mem_req_addr,
  output stencil_pkg::data_t  mem_req_wdata,
  input  logic                mem_req_ready,
  input  logic                mem_rsp_valid,
  input  stencil_pkg::data_t  mem_rsp_rdata
);

  // host wins a tie when prio_host is set
  logic prio_host;
  logic owner_host;
  logic busy;
  logic sel_host;

  assign sel_host = host_req_valid & (prio_host | !eng_req_valid);

  assign mem_req_valid = !busy & (eng_req_valid | host_req_valid);
  assign mem_req_write = sel_host ? host_req_write : eng_req_write;
  assign mem_req_addr = sel_host ? host_req_addr : eng_req_addr;
  assign mem_req_wdata = sel_host ? host_req_wdata : eng_req_wdata;

  assign eng_req_ready = !busy & !sel_host & mem_req_ready;
  assign host_req_ready = !busy & sel_host & mem_req_ready;

  // reply only to the requester that holds the grant
  assign eng_rsp_valid = mem_rsp_valid & busy & !owner_host;
  assign host_rsp_valid = mem_rsp_valid & busy & owner_host;
  assign eng_rsp_rdata = mem_rsp_rdata;
  assign host_rsp_rdata = mem_rsp_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      owner_host <= 1'b0;
      prio_host <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      busy <= 1'b1;
      owner_host <= sel_host;
      // the other side goes first next time
      prio_host <= !sel_host;
    end else if (mem_rsp_valid) begin
      busy <= 1'b0;
    end
  end

endmodule

// File: hdl/stencil_engine.sv
/*
  stencil engine
  fills each interior destination cell with the XOR of the 3x3 source neighbourhood
*/
`timescale 1ns/10ps

module stencil_engine #(
  parameter int REQ_GAP = stencil_pkg::REQ_GAP_DEF
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  output logic                busy,
  output logic                done,
  output logic                req_valid,
  output logic                req_write,
  output stencil_pkg::maddr_t req_addr,
  output stencil_pkg::data_t  req_wdata,
  input  logic                req_ready,
  input  logic                rsp_valid,
  input  stencil_pkg::data_t  rsp_rdata
);

  localparam logic [3:0] GAP = 4'(REQ_GAP);
  localparam logic [2:0] LAST = 3'(stencil_pkg::DIM - 2);

  typedef enum logic [1:0] {
    S_IDLE,
    S_GAP,
    S_REQ,
    S_WAIT
  } state_t;

  // state that follows a finished request
  localparam state_t S_NEXT = (GAP == 4'd0) ? S_REQ : S_GAP;

  state_t             state;
  logic [2:0]         i;
  logic [2:0]         j;
  logic [1:0]         nr;
  logic [1:0]         nc;
  logic               wr_phase;
  logic [3:0]         gap_cnt;
  stencil_pkg::data_t sum;
  logic [2:0]         nb_row;
  logic [2:0]         nb_col;
  logic               last_nb;
  logic               last_cell;

  // ----------------------------------------------------------
  // address generation
  // ----------------------------------------------------------

  // neighbour offsets nr, nc run 0..2 and map to -1..+1
  assign nb_row = i + 3'(nr) - 3'd1;
  assign nb_col = j + 3'(nc) - 3'd1;
  assign last_nb = (nr == 2'd2) && (nc == 2'd2);
  assign last_cell = (i == LAST) && (j == LAST);

  assign req_valid = (state == S_REQ);
  assign req_write = wr_phase;
  assign req_wdata = sum;

  // row stride is DIM, so {row, col} is 8*row + col
  assign req_addr = wr_phase ? stencil_pkg::DST_BASE + {1'b0, i, j}
                             : stencil_pkg::SRC_BASE + {1'b0, nb_row, nb_col};

  // ----------------------------------------------------------
  // sequencer and XOR accumulator
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      busy <= 1'b0;
      done <= 1'b0;
      wr_phase <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_NEXT;
            busy <= 1'b1;
            done <= 1'b0;
            i <= 3'd1;
            j <= 3'd1;
            nr <= 2'd0;
            nc <= 2'd0;
            wr_phase <= 1'b0;
            gap_cnt <= 4'd1;
            sum <= '0;
          end
        end
        S_GAP: begin
          if (gap_cnt == GAP) begin
            state <= S_REQ;
          end else begin
            gap_cnt <= gap_cnt + 4'd1;
          end
        end
        S_REQ: begin
          if (req_ready) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_valid) begin
            gap_cnt <= 4'd1;
            state <= S_NEXT;
            if (!wr_phase) begin
              // read reply goes into the running sum
              sum <= sum ^ rsp_rdata;
              if (nc == 2'd2) begin
                nc <= 2'd0;
                nr <= nr + 2'd1;
              end else begin
                nc <= nc + 2'd1;
              end
              wr_phase <= last_nb;
            end else begin
              // write acknowledged, move to the next cell
              sum <= '0;
              wr_phase <= 1'b0;
              nr <= 2'd0;
              nc <= 2'd0;
              if (last_cell) begin
                state <= S_IDLE;
                busy <= 1'b0;
                done <= 1'b1;
              end else if (j == LAST) begin
                j <= 3'd1;
                i <= i + 3'd1;
              end else begin
                j <= j + 3'd1;
              end
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/stencil_pkg.sv
/*
  stencil accelerator shared definitions
  widths, address map and default parameter values
*/
package stencil_pkg;

  // one matrix element
  typedef logic [7:0] data_t;

  // byte address into the 128-byte memory
  typedef logic [6:0] maddr_t;

  // apb address, one bit wider than the memory
  typedef logic [7:0] paddr_t;

  // ----------------------------------------------------------
  // matrix layout and address map
  // ----------------------------------------------------------
  localparam int DIM = 8;
  localparam maddr_t SRC_BASE = 7'h00;
  localparam maddr_t DST_BASE = 7'h40;
  localparam paddr_t CTRL_ADDR = 8'h80;

  // ----------------------------------------------------------
  // cache geometry and engine pacing
  // ----------------------------------------------------------
  localparam int LINE_COUNT_DEF = 8;
  localparam int LINE_BYTES = 4;
  // idle cycles before each engine request, 0 to 15
  localparam int REQ_GAP_DEF = 2;

endpackage

// File: hdl/stencil_top.sv
/*
  stencil accelerator top level
  apb port and stencil engine share the cache through the arbiter
*/
`timescale 1ns/10ps

module stencil_top #(
  parameter int LINE_COUNT = stencil_pkg::LINE_COUNT_DEF,
  parameter int REQ_GAP = stencil_pkg::REQ_GAP_DEF
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  stencil_pkg::paddr_t paddr,
  input  stencil_pkg::data_t  pwdata,
  output stencil_pkg::data_t  prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                done
);

  logic                start;
  logic                busy;

  logic                eng_req_valid;
  logic                eng_req_write;
  stencil_pkg::maddr_t eng_req_addr;
  stencil_pkg::data_t  eng_req_wdata;
  logic                eng_req_ready;
  logic                eng_rsp_valid;
  stencil_pkg::data_t  eng_rsp_rdata;

  logic                host_req_valid;
  logic                host_req_write;
  stencil_pkg::maddr_t host_req_addr;
  stencil_pkg::data_t  host_req_wdata;
  logic                host_req_ready;
  logic                host_rsp_valid;
  stencil_pkg::data_t  host_rsp_rdata;

  logic                mem_req_valid;
  logic                mem_req_write;
  stencil_pkg::maddr_t mem_req_addr;
  stencil_pkg::data_t  mem_req_wdata;
  logic                mem_req_ready;
  logic                mem_rsp_valid;
  stencil_pkg::data_t  mem_rsp_rdata;

  apb_port u_apb_port (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .start(start), .busy(busy), .done(done),
    .req_valid(host_req_valid), .req_write(host_req_write),
    .req_addr(host_req_addr), .req_wdata(host_req_wdata), .req_ready(host_req_ready),
    .rsp_valid(host_rsp_valid), .rsp_rdata(host_rsp_rdata)
  );

  stencil_engine #(
    .REQ_GAP(REQ_GAP)
  ) u_engine (
    .clk(clk), .rst(rst),
    .start(start), .busy(busy), .done(done),
    .req_valid(eng_req_valid), .req_write(eng_req_write),
    .req_addr(eng_req_addr), .req_wdata(eng_req_wdata), .req_ready(eng_req_ready),
    .rsp_valid(eng_rsp_valid), .rsp_rdata(eng_rsp_rdata)
  );

  req_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .eng_req_valid(eng_req_valid), .eng_req_write(eng_req_write),
    .eng_req_addr(eng_req_addr), .eng_req_wdata(eng_req_wdata),
    .eng_req_ready(eng_req_ready), .eng_rsp_valid(eng_rsp_valid),
    .eng_rsp_rdata(eng_rsp_rdata),
    .host_req_valid(host_req_valid), .host_req_write(host_req_write),
    .host_req_addr(host_req_addr), .host_req_wdata(host_req_wdata),
    .host_req_ready(host_req_ready), .host_rsp_valid(host_rsp_valid),
    .host_rsp_rdata(host_rsp_rdata),
    .mem_req_valid(mem_req_valid), .mem_req_write(mem_req_write),
    .mem_req_addr(mem_req_addr), .mem_req_wdata(mem_req_wdata),
    .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_rdata(mem_rsp_rdata)
  );

  cache_mem #(
    .LINE_COUNT(LINE_COUNT)
  ) u_cache (
    .clk(clk), .rst(rst),
    .req_valid(mem_req_valid), .req_write(mem_req_write),
    .req_addr(mem_req_addr), .req_wdata(mem_req_wdata), .req_ready(mem_req_ready),
    .rsp_valid(mem_rsp_valid), .rsp_rdata(mem_rsp_rdata)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the stencil testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stencil_tb -f tb.f -o Vstencil_tb
./obj_dir/Vstencil_tb 2>&1 | tee sim.log
if grep -q "Some tests failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a pass line"
  exit 1
fi
echo "simulation finished cleanly"

// File: tb.f
hdl/stencil_pkg.sv
hdl/stencil_engine.sv
hdl/apb_port.sv
hdl/req_arbiter.sv
hdl/cache_mem.sv
hdl/stencil_top.sv
tests/stencil_chk.sv
tests/stencil_tb.sv

// File: tests/stencil_chk.sv
/*
  protocol checks bound into the stencil top level
  APB stability and error rules, request hold and reply ownership
*/
`timescale 1ns/10ps

module stencil_chk (
  input logic                clk,
  input logic                rst,
  input logic                psel,
  input logic                penable,
  input logic                pwrite,
  input stencil_pkg::paddr_t paddr,
  input stencil_pkg::data_t  pwdata,
  input logic                pready,
  input logic                pslverr,
  input logic                eng_req_valid,
  input logic                eng_req_write,
  input stencil_pkg::maddr_t eng_req_addr,
  input stencil_pkg::data_t  eng_req_wdata,
  input logic                eng_req_ready,
  input logic                mem_req_valid,
  input logic                mem_req_ready,
  input logic                mem_rsp_valid
);

  // a cache request has been granted and not yet answered
  logic outstanding;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      outstanding <= 1'b1;
    end else if (mem_rsp_valid) begin
      outstanding <= 1'b0;
    end
  end

  apb_stable: assert property (@(posedge clk) disable iff (rst)
    (psel && penable && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
    else $error("APB address or data changed during a wait state");

  apb_err_ready: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> pready)
    else $error("pslverr without pready");

  eng_hold: assert property (@(posedge clk) disable iff (rst)
    (eng_req_valid && !eng_req_ready) |=>
      (eng_req_valid && $stable(eng_req_write) && $stable(eng_req_addr)
       && $stable(eng_req_wdata)))
    else $error("engine request dropped or changed before ready");

  rsp_owned: assert property (@(posedge clk) disable iff (rst)
    mem_rsp_valid |-> outstanding)
    else $error("cache reply without an outstanding grant");

endmodule

bind stencil_top stencil_chk u_chk (
  .clk(clk), .rst(rst),
  .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
  .pready(pready), .pslverr(pslverr),
  .eng_req_valid(eng_req_valid), .eng_req_write(eng_req_write),
  .eng_req_addr(eng_req_addr), .eng_req_wdata(eng_req_wdata),
  .eng_req_ready(eng_req_ready),
  .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
  .mem_rsp_valid(mem_rsp_valid)
);

// File: tests/stencil_tb.sv
/*
  stencil accelerator testbench
  directed APB tests against a software stencil model
*/
`timescale 1ns/10ps

module stencil_tb;

  // cycles allowed for one APB transfer and for one engine run
  localparam int XFER_TIMEOUT = 200;
  localparam int RUN_TIMEOUT = 20000;

  logic                clk;
  logic                rst;
  logic                psel;
  logic                penable;
  logic                pwrite;
  stencil_pkg::paddr_t paddr;
  stencil_pkg::data_t  pwdata;
  stencil_pkg::data_t  prdata;
  logic                pready;
  logic                pslverr;
  logic                done;

  // expected contents of the 128-byte memory
  stencil_pkg::data_t  mem_model [128];

  stencil_top stencil_top_inst (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .done(done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ----------------------------------------------------------
  // reporting and compare tasks
  // ----------------------------------------------------------
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_data(input string test, input stencil_pkg::data_t exp,
                              input stencil_pkg::data_t act);
    if (act !== exp) begin
      stop_run($sformatf("error %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic compare_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("error %s: expected %b, actual %b", test, exp, act));
    end
  endtask

  // ----------------------------------------------------------
  // APB bus tasks
  // ----------------------------------------------------------
  task automatic apb_transfer(input logic wr, input stencil_pkg::paddr_t a,
                              input stencil_pkg::data_t wd,
                              output stencil_pkg::data_t rd, output logic err);
    int cnt;
    cnt = 0;
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = a;
    pwdata = wd;
    @(negedge clk);
    penable = 1'b1;
    // sample a little after the falling edge, when pready has settled
    #1;
    while (pready !== 1'b1) begin
      if (cnt == XFER_TIMEOUT) begin
        stop_run($sformatf("timeout: no pready for APB transfer to address %h", a));
      end
      cnt++;
      @(negedge clk);
      #1;
    end
    rd = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input stencil_pkg::paddr_t a, input stencil_pkg::data_t d,
                           output logic err);
    stencil_pkg::data_t unused;
    apb_transfer(1'b1, a, d, unused, err);
  endtask

  task automatic apb_read(input stencil_pkg::paddr_t a, output stencil_pkg::data_t d,
                          output logic err);
    apb_transfer(1'b0, a, 8'h00, d, err);
  endtask

  // ----------------------------------------------------------
  // memory, control and model helpers
  // ----------------------------------------------------------
  task automatic mem_write(input int a, input stencil_pkg::data_t d);
    logic err;
    apb_write(stencil_pkg::paddr_t'(a), d, err);
    compare_flag($sformatf("write %0d pslverr", a), 1'b0, err);
    mem_model[a] = d;
  endtask

  task automatic mem_check(input string test, input int a);
    stencil_pkg::data_t d;
    logic err;
    apb_read(stencil_pkg::paddr_t'(a), d, err);
    compare_flag({test, " pslverr"}, 1'b0, err);
    compare_data($sformatf("%s addr %0d", test, a), mem_model[a], d);
  endtask

  task automatic start_engine;
    logic err;
    apb_write(stencil_pkg::CTRL_ADDR, 8'h01, err);
    compare_flag("start pslverr", 1'b0, err);
  endtask

  task automatic check_status(input string test, input logic exp_busy, input logic exp_done);
    stencil_pkg::data_t d;
    logic err;
    apb_read(stencil_pkg::CTRL_ADDR, d, err);
    compare_flag({test, " busy"}, exp_busy, d[0]);
    compare_flag({test, " done"}, exp_done, d[1]);
  endtask

  task automatic wait_done;
    int cnt;
    cnt = 0;
    while (done !== 1'b1) begin
      if (cnt == RUN_TIMEOUT) begin
        stop_run("timeout: engine never raised done");
      end
      cnt++;
      @(negedge clk);
    end
  endtask

  // XOR of the 3x3 source neighbourhood around (r, c)
  function automatic stencil_pkg::data_t stencil_cell(input int r, input int c);
    stencil_pkg::data_t acc;
    acc = '0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        acc ^= mem_model[int'(stencil_pkg::SRC_BASE) + 8 * (r + dr) + (c + dc)];
      end
    end
    return acc;
  endfunction

  task automatic load_source;
    for (int k = 0; k < 64; k++) begin
      mem_write(int'(stencil_pkg::SRC_BASE) + k, 8'($urandom));
    end
  endtask

  task automatic check_result(input string test);
    int a;
    for (int r = 0; r < stencil_pkg::DIM; r++) begin
      for (int c = 0; c < stencil_pkg::DIM; c++) begin
        a = int'(stencil_pkg::DST_BASE) + 8 * r + c;
        if (r == 0 || c == 0 || r == stencil_pkg::DIM - 1 || c == stencil_pkg::DIM - 1) begin
          mem_model[a] = 8'h00;
        end else begin
          mem_model[a] = stencil_cell(r, c);
        end
        mem_check(test, a);
      end
    end
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset;
    compare_flag("reset done output", 1'b0, done);
    check_status("reset status", 1'b0, 1'b0);
  endtask

  task automatic test_memory;
    for (int a = 0; a < 128; a++) begin
      mem_write(a, 8'($urandom));
    end
    // ascending pass misses on each line start, then hits the rest
    for (int a = 0; a < 128; a++) begin
      mem_check("memory ascending", a);
    end
    for (int a = 127; a >= 0; a--) begin
      mem_check("memory descending", a);
    end
    // address 5 is cached here, address 37 maps to the same line
    mem_check("memory hit", 5);
    mem_write(5, ~mem_model[5]);
    mem_check("write-through hit", 5);
    mem_write(37, ~mem_model[37]);
    mem_check("write-through miss", 37);
    // line of address 5 was replaced by 37, so this read refills from the backing array
    mem_check("write-through evicted", 5);
  endtask

  task automatic test_bad_addr;
    stencil_pkg::data_t d;
    logic err;
    apb_read(8'h90, d, err);
    compare_flag("bad addr read pslverr", 1'b1, err);
    compare_data("bad addr read prdata", 8'h00, d);
    apb_write(8'hff, 8'h5a, err);
    compare_flag("bad addr write pslverr", 1'b1, err);
    mem_check("after bad addr", 8'h11);
  endtask

  task automatic test_stencil;
    load_source();
    for (int k = 0; k < 64; k++) begin
      mem_write(int'(stencil_pkg::DST_BASE) + k, 8'h00);
    end
    start_engine();
    wait_done();
    check_status("stencil status", 1'b0, 1'b1);
    check_result("stencil result");
  endtask

  task automatic test_concurrent;
    load_source();
    start_engine();
    check_status("concurrent status", 1'b1, 1'b0);
    for (int k = 0; k < 12; k++) begin
      mem_check("concurrent source read", int'(stencil_pkg::SRC_BASE) + $urandom_range(63));
    end
    // a start while busy must not restart the engine
    start_engine();
    check_status("second start status", 1'b1, 1'b0);
    wait_done();
    check_result("concurrent result");
    check_status("final status", 1'b0, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h14f3_314b));
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_memory();
    test_bad_addr();
    test_stencil();
    test_concurrent();

    $display("All tests passed");
    $finish;
  end

endmodule
